// File: Makefile
TOP = tb_arcade_game

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: list.f
logic/arcade_pkg.sv
logic/cen_gen.sv
logic/video_timer.sv
logic/rom_download.sv
logic/rom_slot_arbiter.sv
logic/arcade_game.sv
tb/sdram_model.sv
tb/tb_arcade_game.sv

// File: logic/arcade_game.sv
`timescale 1ns/1ps

module arcade_game (
    input  logic        clk,
    input  logic        arst_n,
    // Clock enables
    output logic        pxl2_cen,   // 16 MHz
    output logic        pxl_cen,    // 8 MHz
    output logic        cpu_cen,    // 4 MHz
    // Video timing
    output logic [8:0]  h,
    output logic [8:0]  v,
    output logic        lhbl,
    output logic        lvbl,
    output logic        hs,
    output logic        vs,
    output logic        hinit,
    // ROM loader
    input  logic        downloading,
    output logic        dwnld_busy,
    input  logic        loop_rst,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    output logic [arcade_pkg::sdram_aw-1:0] prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    // SDRAM
    output logic        sdram_req,
    output logic [arcade_pkg::sdram_aw-1:0] sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [31:0] data_read,
    output logic        refresh_en,
    // Main CPU ROM
    input  logic        main_cs,
    input  logic [arcade_pkg::main_aw-1:0] main_addr,
    output logic [7:0]  main_data,
    output logic        main_ok,
    // Char ROM
    input  logic [arcade_pkg::char_aw-1:0] char_addr,
    output logic [15:0] char_data,
    output logic        char_ok,
    // Object ROM
    input  logic [arcade_pkg::obj_aw-1:0]  obj_addr,
    output logic [15:0] obj_data,
    output logic        obj_ok
);

    logic vblank;

    assign vblank = ~lvbl;  // Refresh window

    cen_gen u_cen (
        .clk    ( clk      ),
        .arst_n ( arst_n   ),
        .cen16  ( pxl2_cen ),
        .cen8   ( pxl_cen  ),
        .cen4   ( cpu_cen  )
    );

    video_timer u_timer (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .pxl_cen ( pxl_cen ),
        .h       ( h       ),
        .v       ( v       ),
        .lhbl    ( lhbl    ),
        .lvbl    ( lvbl    ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .hinit   ( hinit   )
    );

    rom_download u_dwnld (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .dwnld_busy  ( dwnld_busy  ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     )
    );

    rom_slot_arbiter u_rom (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .loop_rst    ( loop_rst    ),
        .vblank      ( vblank      ),
        .main_cs     ( main_cs     ),
        .main_addr   ( main_addr   ),
        .char_cs     ( lvbl        ),  // Char fetches only in active lines
        .char_addr   ( char_addr   ),
        .obj_addr    ( obj_addr    ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .main_data   ( main_data   ),
        .main_ok     ( main_ok     ),
        .char_data   ( char_data   ),
        .char_ok     ( char_ok     ),
        .obj_data    ( obj_data    ),
        .obj_ok      ( obj_ok      ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  ),
        .refresh_en  ( refresh_en  )
    );

endmodule

// File: logic/arcade_pkg.sv
package arcade_pkg;

    // Address widths
    localparam int sdram_aw = 22;  // SDRAM word address, 16-bit units
    localparam int main_aw  = 17;  // Main CPU byte address
    localparam int char_aw  = 14;  // Char word address
    localparam int obj_aw   = 17;  // Object word address

    // ROM regions inside the SDRAM, in 16-bit words
    localparam logic [sdram_aw-1:0] main_offset = 22'h00000;
    localparam logic [sdram_aw-1:0] char_offset = 22'h14000;
    localparam logic [sdram_aw-1:0] obj_offset  = 22'h36000;

    // Horizontal timing in pixels
    localparam logic [8:0] h_total   = 9'd384;
    localparam logic [8:0] h_visible = 9'd256;  // LHBL high below this
    localparam logic [8:0] hs_start  = 9'd304;
    localparam logic [8:0] hs_end    = 9'd336;  // First pixel after HS

    // Vertical timing in lines
    localparam logic [8:0] v_total  = 9'd256;
    localparam logic [8:0] vb_end   = 9'd16;   // First visible line
    localparam logic [8:0] vb_start = 9'd240;  // First blanked line
    localparam logic [8:0] vs_start = 9'd248;
    localparam logic [8:0] vs_end   = 9'd252;

    // ROM request engine
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,   // sdram_req held up
        ARB_WAIT_DATA   // Acked, line still to come
    } arb_state_t;

    // ROM clients, listed in priority order
    typedef enum logic [1:0] {
        SLOT_MAIN,
        SLOT_CHAR,
        SLOT_OBJ
    } slot_id_t;

endpackage

// File: logic/cen_gen.sv
`timescale 1ns/1ps

module cen_gen (
    input  logic clk,
    input  logic arst_n,
    output logic cen16,
    output logic cen8,
    output logic cen4
);

    // 48 MHz split into twelve phases
    logic [3:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt   <= 4'd0;
            cen16 <= 1'b0;
            cen8  <= 1'b0;
            cen4  <= 1'b0;
        end else begin
            cnt <= (cnt == 4'd11) ? 4'd0 : cnt + 4'd1;

            // All three line up on phase 0
            cen4  <= (cnt == 4'd0);
            cen8  <= (cnt == 4'd0) || (cnt == 4'd6);
            case (cnt)
                4'd0, 4'd3, 4'd6, 4'd9: cen16 <= 1'b1;
                default:                cen16 <= 1'b0;
            endcase
        end
    end

endmodule

// File: logic/rom_download.sv
`timescale 1ns/1ps

module rom_download (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output logic        dwnld_busy,
    output logic [arcade_pkg::sdram_aw-1:0] prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we
);

    import arcade_pkg::*;

    logic byte_wr;

    assign byte_wr    = downloading && ioctl_wr;
    assign dwnld_busy = downloading;  // No read-back during load

    // Odd bytes land in the upper half of the word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_addr <= '0;
            prog_data <= 8'd0;
            prog_mask <= 2'b11;
        end else if (byte_wr) begin
            prog_addr <= ioctl_addr[sdram_aw:1];
            prog_data <= ioctl_data;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

    // Write strobe held until the SDRAM takes it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
        end else if (byte_wr) begin
            prog_we <= 1'b1;
        end else if (sdram_ack) begin
            prog_we <= 1'b0;
        end
    end

endmodule

// File: logic/rom_slot_arbiter.sv
`timescale 1ns/1ps

module rom_slot_arbiter (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  logic        loop_rst,
    input  logic        vblank,
    input  logic        main_cs,
    input  logic [arcade_pkg::main_aw-1:0] main_addr,
    input  logic        char_cs,
    input  logic [arcade_pkg::char_aw-1:0] char_addr,
    input  logic [arcade_pkg::obj_aw-1:0]  obj_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [31:0] data_read,
    output logic [7:0]  main_data,
    output logic        main_ok,
    output logic [15:0] char_data,
    output logic        char_ok,
    output logic [15:0] obj_data,
    output logic        obj_ok,
    output logic        sdram_req,
    output logic [arcade_pkg::sdram_aw-1:0] sdram_addr,
    output logic        refresh_en
);

    import arcade_pkg::*;

    arb_state_t state;
    slot_id_t   sel;       // Slot waiting for its line
    slot_id_t   next_sel;
    logic [2:0] valid;

    // One 32-bit line per slot
    logic [31:0]        main_line, char_line, obj_line;
    logic [main_aw-3:0] main_tag;
    logic [char_aw-2:0] char_tag;
    logic [obj_aw-2:0]  obj_tag;
    logic [obj_aw-2:0]  req_tag;   // Sized for the widest tag
    logic [obj_aw-2:0]  next_tag;

    logic main_hit, char_hit, obj_hit;
    logic main_miss, char_miss, obj_miss;
    logic start;
    logic [sdram_aw-1:0] base;
    logic [sdram_aw-1:0] line_word;

    assign main_hit = valid[SLOT_MAIN] && (main_tag == main_addr[main_aw-1:2]);
    assign char_hit = valid[SLOT_CHAR] && (char_tag == char_addr[char_aw-1:1]);
    assign obj_hit  = valid[SLOT_OBJ]  && (obj_tag == obj_addr[obj_aw-1:1]);

    assign main_ok = main_cs && main_hit;
    assign char_ok = char_cs && char_hit;
    assign obj_ok  = obj_hit;             // Object slot is always selected

    assign main_miss = main_cs && !main_hit;
    assign char_miss = char_cs && !char_hit;
    assign obj_miss  = !obj_hit;

    // Little endian byte pick with the low word first
    assign main_data = main_line[8*main_addr[1:0] +: 8];
    assign char_data = char_addr[0] ? char_line[31:16] : char_line[15:0];
    assign obj_data  = obj_addr[0] ? obj_line[31:16] : obj_line[15:0];

    assign start      = (state == ARB_IDLE) && !downloading &&
                        (main_miss || char_miss || obj_miss);
    assign refresh_en = (state == ARB_IDLE) && vblank;

    // Fixed priority main > char > obj on the even word of the line
    always_comb begin
        next_sel  = SLOT_OBJ;
        base      = obj_offset;
        line_word = '0;
        next_tag  = '0;
        if (main_miss) begin
            next_sel                   = SLOT_MAIN;
            base                       = main_offset;
            line_word[main_aw-2:1]     = main_addr[main_aw-1:2];
            next_tag[main_aw-3:0]      = main_addr[main_aw-1:2];
        end else if (char_miss) begin
            next_sel                   = SLOT_CHAR;
            base                       = char_offset;
            line_word[char_aw-1:1]     = char_addr[char_aw-1:1];
            next_tag[char_aw-2:0]      = char_addr[char_aw-1:1];
        end else begin
            line_word[obj_aw-1:1]      = obj_addr[obj_aw-1:1];
            next_tag                   = obj_addr[obj_aw-1:1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ARB_IDLE;
            sel       <= SLOT_MAIN;
            sdram_req <= 1'b0;
            valid     <= 3'b000;
        end else begin
            case (state)
                ARB_IDLE: if (start) begin
                    sel       <= next_sel;
                    sdram_req <= 1'b1;
                    state     <= ARB_WAIT_ACK;
                end
                ARB_WAIT_ACK: if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= ARB_WAIT_DATA;
                end
                ARB_WAIT_DATA: if (data_rdy) begin
                    valid[sel] <= 1'b1;
                    state      <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
            // New ROM contents or a game restart drop every line
            if (downloading || loop_rst) begin
                valid <= 3'b000;
            end
        end
    end

    // Address latched at the request and held through back-pressure
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sdram_addr <= '0;
            req_tag    <= '0;
            main_line  <= '0;
            char_line  <= '0;
            obj_line   <= '0;
            main_tag   <= '0;
            char_tag   <= '0;
            obj_tag    <= '0;
        end else begin
            if (start) begin
                sdram_addr <= base + line_word;
                req_tag    <= next_tag;
            end
            if (state == ARB_WAIT_DATA && data_rdy) begin
                case (sel)
                    SLOT_MAIN: begin
                        main_line <= data_read;
                        main_tag  <= req_tag[main_aw-3:0];
                    end
                    SLOT_CHAR: begin
                        char_line <= data_read;
                        char_tag  <= req_tag[char_aw-2:0];
                    end
                    default: begin
                        obj_line <= data_read;
                        obj_tag  <= req_tag;
                    end
                endcase
            end
        end
    end

endmodule

// File: logic/video_timer.sv
`timescale 1ns/1ps

module video_timer (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       pxl_cen,
    output logic [8:0] h,
    output logic [8:0] v,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs,
    output logic       hinit
);

    import arcade_pkg::*;

    logic [8:0] h_next;
    logic [8:0] v_next;
    logic       h_wrap;

    // Counter values for the coming pixel step
    always_comb begin
        h_wrap = (h == h_total - 9'd1);
        h_next = h_wrap ? 9'd0 : h + 9'd1;
        v_next = v;
        if (h_wrap) begin
            v_next = (v == v_total - 9'd1) ? 9'd0 : v + 9'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h <= 9'd0;
            v <= 9'd0;
        end else if (pxl_cen) begin
            h <= h_next;
            v <= v_next;
        end
    end

    // Decoded from the next values so they switch with H and V
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lhbl <= 1'b1;  // H=0 is visible
            lvbl <= 1'b0;  // V=0 is inside vertical blank
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else if (pxl_cen) begin
            lhbl <= (h_next < h_visible);
            lvbl <= (v_next >= vb_end) && (v_next < vb_start);
            hs   <= (h_next >= hs_start) && (h_next < hs_end);
            vs   <= (v_next >= vs_start) && (v_next < vs_end);
        end
    end

    // Line start strobe, one clk wide
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hinit <= 1'b0;
        end else begin
            hinit <= pxl_cen && h_wrap;
        end
    end

endmodule

// File: tb/sdram_model.sv
`timescale 1ns/1ps

module sdram_model (
    input  logic        clk,
    input  logic [21:0] prog_addr,
    input  logic [7:0]  prog_data,
    input  logic [1:0]  prog_mask,
    input  logic        prog_we,
    input  logic        sdram_req,
    input  logic [21:0] sdram_addr,
    output logic        sdram_ack,
    output logic        data_rdy,
    output logic [31:0] data_read
);

    logic [15:0] mem [0:(1<<22)-1];  // One word per 16-bit address
    logic [21:0] rd_addr;
    int          delay;

    initial begin
        sdram_ack <= 1'b0;
        data_rdy  <= 1'b0;
        data_read <= '0;
        forever begin
            @(posedge clk);
            if (prog_we) begin
                delay = $urandom_range(3, 1);
                repeat (delay - 1) @(posedge clk);
                // Mask bit low means that byte lane is written
                if (!prog_mask[0]) begin
                    mem[prog_addr][7:0] <= prog_data;
                end
                if (!prog_mask[1]) begin
                    mem[prog_addr][15:8] <= prog_data;
                end
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
            end else if (sdram_req) begin
                delay = $urandom_range(4, 1);
                repeat (delay - 1) @(posedge clk);
                rd_addr = sdram_addr;  // Held steady until the ack
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                delay = $urandom_range(6, 2);
                repeat (delay - 1) @(posedge clk);
                data_read <= {mem[rd_addr + 22'd1], mem[rd_addr]};
                data_rdy  <= 1'b1;
                @(posedge clk);
                data_rdy  <= 1'b0;
            end
        end
    end

endmodule

// File: tb/tb_arcade_game.sv
`timescale 1ns/1ps

module tb_arcade_game;

    // One 590k-cycle frame, the loader and the reads, plus margin
    localparam int timeout_cycles = 800000;

    logic        clk;
    logic        arst_n;
    logic        pxl2_cen, pxl_cen, cpu_cen;
    logic [8:0]  h, v;
    logic        lhbl, lvbl, hs, vs, hinit;
    logic        downloading, dwnld_busy, loop_rst, ioctl_wr;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data, prog_data, main_data;
    logic [21:0] prog_addr, sdram_addr;
    logic [1:0]  prog_mask;
    logic        prog_we, sdram_req, sdram_ack, data_rdy, refresh_en;
    logic [31:0] data_read;
    logic        main_cs, main_ok, char_ok, obj_ok;
    logic [16:0] main_addr, obj_addr;
    logic [13:0] char_addr;
    logic [15:0] char_data, obj_data;

    // Reference state
    logic [7:0]  rom_bytes [3][256];  // Bytes sent per region
    logic [21:0] exp_addr;
    logic [7:0]  exp_data, exp_main;
    logic [1:0]  exp_mask;
    logic [15:0] exp_char, exp_obj;
    logic [8:0]  exp_h, exp_v;
    logic        exp16, exp8, exp4, exp_lhbl, exp_hs, exp_lvbl, exp_vs;
    int          run_cyc = 0;
    int          cyc = 0;
    int          errors = 0;
    int          n_tests = 0;
    int          n_failed = 0;
    int          test_start_err = 0;

    arcade_game i_arcade_game (.*);
    sdram_model u_sdram (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected counters step on the expected pixel enable
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_cyc <= 0;
            exp_h   <= 9'd0;
            exp_v   <= 9'd0;
        end else begin
            run_cyc <= run_cyc + 1;
            if (exp8) begin
                exp_h <= (exp_h == 9'd383) ? 9'd0 : exp_h + 9'd1;
                if (exp_h == 9'd383) begin
                    exp_v <= (exp_v == 9'd255) ? 9'd0 : exp_v + 9'd1;
                end
            end
        end
    end

    assign exp16    = (run_cyc > 0) && ((run_cyc - 1) % 3 == 0);
    assign exp8     = (run_cyc > 0) && ((run_cyc - 1) % 6 == 0);
    assign exp4     = (run_cyc > 0) && ((run_cyc - 1) % 12 == 0);
    assign exp_lhbl = exp_h < 9'd256;
    assign exp_hs   = (exp_h >= 9'd304) && (exp_h < 9'd336);
    assign exp_lvbl = (exp_v >= 9'd16) && (exp_v < 9'd240);
    assign exp_vs   = (exp_v >= 9'd248) && (exp_v < 9'd252);
    assign exp_main = rom_bytes[0][main_addr[7:0]];
    assign exp_char = {rom_bytes[1][{char_addr[6:0], 1'b1}],
                       rom_bytes[1][{char_addr[6:0], 1'b0}]};
    assign exp_obj  = {rom_bytes[2][{obj_addr[6:0], 1'b1}],
                       rom_bytes[2][{obj_addr[6:0], 1'b0}]};

    task automatic log_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        errors++;
        $display("MISMATCH %s: got 0x%0h expected 0x%0h (cycle %0d)", name, got, want, cyc);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("ERROR at cycle %0d: %s", cyc, what);
    endtask

    task automatic close_test(input string name);
        n_tests++;
        if (errors != test_start_err) begin
            n_failed++;
        end
        $display("test %-9s %s", name, (errors == test_start_err) ? "ok" : "failed");
        test_start_err = errors;
    endtask

    a_cen16: assert property (@(posedge clk) disable iff (!arst_n) pxl2_cen == exp16)
        else log_mismatch("pxl2_cen", $sampled(pxl2_cen), $sampled(exp16));
    a_cen8: assert property (@(posedge clk) disable iff (!arst_n) pxl_cen == exp8)
        else log_mismatch("pxl_cen", $sampled(pxl_cen), $sampled(exp8));
    a_cen4: assert property (@(posedge clk) disable iff (!arst_n) cpu_cen == exp4)
        else log_mismatch("cpu_cen", $sampled(cpu_cen), $sampled(exp4));
    a_align: assert property (@(posedge clk) disable iff (!arst_n) pxl_cen |-> pxl2_cen)
        else note_failure("pxl_cen pulsed without pxl2_cen");

    // Video timing
    a_h: assert property (@(posedge clk) disable iff (!arst_n) h == exp_h)
        else log_mismatch("h", $sampled(h), $sampled(exp_h));
    a_v: assert property (@(posedge clk) disable iff (!arst_n) v == exp_v)
        else log_mismatch("v", $sampled(v), $sampled(exp_v));
    a_lhbl: assert property (@(posedge clk) disable iff (!arst_n) lhbl == exp_lhbl)
        else log_mismatch("lhbl", $sampled(lhbl), $sampled(exp_lhbl));
    a_hs: assert property (@(posedge clk) disable iff (!arst_n) hs == exp_hs)
        else log_mismatch("hs", $sampled(hs), $sampled(exp_hs));
    a_lvbl: assert property (@(posedge clk) disable iff (!arst_n) lvbl == exp_lvbl)
        else log_mismatch("lvbl", $sampled(lvbl), $sampled(exp_lvbl));
    a_vs: assert property (@(posedge clk) disable iff (!arst_n) vs == exp_vs)
        else log_mismatch("vs", $sampled(vs), $sampled(exp_vs));
    a_hinit: assert property (@(posedge clk) disable iff (!arst_n)
        hinit == ($past(exp8) && exp_h == 9'd0))
        else log_mismatch("hinit", $sampled(hinit), !$sampled(hinit));

    // Loader writes
    a_paddr: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we |-> prog_addr == exp_addr)
        else log_mismatch("prog_addr", $sampled(prog_addr), $sampled(exp_addr));
    a_pdata: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we |-> prog_data == exp_data)
        else log_mismatch("prog_data", $sampled(prog_data), $sampled(exp_data));
    a_pmask: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we |-> prog_mask == exp_mask)
        else log_mismatch("prog_mask", $sampled(prog_mask), $sampled(exp_mask));
    a_we_hold: assert property (@(posedge clk) disable iff (!arst_n)
        $past(prog_we) && !$past(sdram_ack) |-> prog_we)
        else note_failure("prog_we dropped before the SDRAM acknowledge");
    a_we_drop: assert property (@(posedge clk) disable iff (!arst_n)
        $past(prog_we && sdram_ack) && !$past(ioctl_wr) |-> !prog_we)
        else note_failure("prog_we still high after the SDRAM acknowledge");
    a_busy: assert property (@(posedge clk) disable iff (!arst_n) dwnld_busy == downloading)
        else log_mismatch("dwnld_busy", $sampled(dwnld_busy), $sampled(downloading));

    // ROM slots
    a_main: assert property (@(posedge clk) disable iff (!arst_n)
        main_ok |-> main_data == exp_main)
        else log_mismatch("main_data", $sampled(main_data), $sampled(exp_main));
    a_char: assert property (@(posedge clk) disable iff (!arst_n)
        char_ok |-> char_data == exp_char)
        else log_mismatch("char_data", $sampled(char_data), $sampled(exp_char));
    a_obj: assert property (@(posedge clk) disable iff (!arst_n)
        obj_ok |-> obj_data == exp_obj)
        else log_mismatch("obj_data", $sampled(obj_data), $sampled(exp_obj));
    a_char_vb: assert property (@(posedge clk) disable iff (!arst_n) !lvbl |-> !char_ok)
        else note_failure("char_ok high during vertical blanking");
    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        $past(sdram_req && !sdram_ack) |-> sdram_req && $stable(sdram_addr))
        else note_failure("sdram_req or sdram_addr changed before the SDRAM acknowledge");
    a_refresh: assert property (@(posedge clk) disable iff (!arst_n)
        refresh_en |-> !lvbl && !sdram_req)
        else note_failure("refresh_en high during active lines or an SDRAM request");
    a_loop_rst: assert property (@(posedge clk) disable iff (!arst_n)
        $past(loop_rst && main_ok) |-> !main_ok)
        else note_failure("main_ok still high on the cycle after loop_rst");

    task automatic load_region(input int r, input logic [24:0] base);
        logic [7:0] b;
        for (int i = 0; i < 256; i++) begin
            b = 8'($urandom);
            rom_bytes[r][i] = b;
            @(posedge clk);
            ioctl_addr <= base + 25'(i);
            ioctl_data <= b;
            ioctl_wr   <= 1'b1;
            exp_addr   <= 22'((base + 25'(i)) >> 1);
            exp_data   <= b;
            exp_mask   <= i[0] ? 2'b01 : 2'b10;  // Odd bytes in the upper half
            @(posedge clk);
            ioctl_wr <= 1'b0;
            do @(posedge clk); while (prog_we);
        end
    endtask

    task automatic fetch_main(input logic [16:0] a);
        @(posedge clk);
        main_cs   <= 1'b1;
        main_addr <= a;
        do @(posedge clk); while (!main_ok);
    endtask

    task automatic fetch_gfx(input logic [13:0] ca, input logic [16:0] oa);
        @(posedge clk);
        char_addr <= ca;
        obj_addr  <= oa;
        do @(posedge clk); while (!(char_ok && obj_ok));
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc == timeout_cycles) begin
            $display("Timeout: run stopped after %0d cycles, a wait never ended", cyc);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        void'($urandom(81));
        arst_n      <= 1'b0;
        downloading <= 1'b1;  // Loader owns the SDRAM from power-up
        loop_rst    <= 1'b0;
        ioctl_wr    <= 1'b0;
        ioctl_addr  <= '0;
        ioctl_data  <= '0;
        main_cs     <= 1'b0;
        main_addr   <= '0;
        char_addr   <= '0;
        obj_addr    <= '0;
        exp_addr    <= '0;
        exp_data    <= '0;
        exp_mask    <= '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        repeat (48) @(posedge clk);
        close_test("enables");

        // Byte addresses are twice the word offsets
        load_region(0, 25'h000000);
        load_region(1, 25'h028000);
        load_region(2, 25'h06c000);
        @(posedge clk);
        downloading <= 1'b0;
        close_test("download");

        for (int i = 0; i < 24; i++)
            fetch_main(17'($urandom % 256));
        close_test("main");

        for (int i = 0; i < 16; i++)
            fetch_gfx(14'($urandom % 128), 17'($urandom % 128));
        close_test("gfx");

        do @(posedge clk); while (!refresh_en);  // Wait for the blanking window
        fetch_main(17'($urandom % 256));
        loop_rst <= 1'b1;
        @(posedge clk);
        loop_rst <= 1'b0;
        do @(posedge clk); while (!main_ok);
        close_test("refresh");

        // Run out the first frame
        do @(posedge clk); while (v != 9'd255);
        do @(posedge clk); while (v != 9'd0);
        repeat (4) @(posedge clk);
        close_test("video");

        $display("tests run %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
